/* Makefile */
sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mem_top_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vmem_top_tb 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* rtl/cache.sv */
`include "cache_settings.svh"

module cache
    import cache_pkg::*;
#(
    parameter cache_type_t CACHE_TYPE = DCACHE
) (
    input  logic       clk,
    input  logic       rst_aL,
    input  core_req_t  core_req,
    output core_resp_t core_resp,
    output mem_req_t   mem_req,
    input  logic       mem_ready,
    input  mem_resp_t  mem_resp
);

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    logic                    rand_way;
    core_req_t               req_q;             // follows core_req one cycle late
    logic                    resp_was_valid;
    logic                    refill_wait;       // block read issued, refill not yet looked up
    logic                    relook;            // refill written last cycle
    tag_entry_t [1:0]        tag_dout;
    block_t     [1:0]        data_dout;
    logic [1:0]              way_hit;
    logic                    any_hit;
    logic                    active;
    logic                    is_store;
    logic [1:0]              victim;
    logic                    refill_wr;
    logic                    store_wr;
    logic                    arr_en;
    logic [INDEX_BITS-1:0]   arr_addr;
    logic [`BLOCK_BYTES-1:0] byte_mask;
    block_t                  store_blk;
    block_t                  hit_blk;
    block_t                  merged_blk;
    block_t     [1:0]        data_din;

    lfsr_8bit lfsr_i (
        .clk     (clk),
        .rst_aL  (rst_aL),
        .out_bit (rand_way)
    );

    // lookup result for the held request
    assign way_hit[0] = tag_dout[0].valid && (tag_dout[0].tag == req_q.addr.cache_view.tag);
    assign way_hit[1] = tag_dout[1].valid && (tag_dout[1].tag == req_q.addr.cache_view.tag);
    assign any_hit    = |way_hit;
    assign hit_blk    = way_hit[1] ? data_dout[1] : data_dout[0];
    assign is_store   = (req_q.req_type == WRITE);
    assign active     = req_q.valid && !resp_was_valid;

    // fill an empty way first, random way once the set is full
    assign victim = !tag_dout[0].valid ? 2'b01 :
                    !tag_dout[1].valid ? 2'b10 :
                                         {rand_way, !rand_way};

    always_comb begin
        case (req_q.width)
            BYTE: begin
                byte_mask = `BLOCK_BYTES'(1) << req_q.addr.cache_view.offset;
                store_blk = {(`BLOCK_BYTES){req_q.wr_data[7:0]}};
            end
            HALFWORD: begin
                byte_mask = `BLOCK_BYTES'(3) << req_q.addr.cache_view.offset;
                store_blk = {(`BLOCK_BYTES/2){req_q.wr_data[15:0]}};
            end
            default: begin
                byte_mask = `BLOCK_BYTES'(15) << req_q.addr.cache_view.offset;
                store_blk = {(`BLOCK_BYTES/4){req_q.wr_data}};
            end
        endcase
    end

    // hit block with the store bytes laid over it
    always_comb begin
        for (int b = 0; b < `BLOCK_BYTES; b++) begin
            merged_blk[8*b +: 8] = byte_mask[b] ? store_blk[8*b +: 8] : hit_blk[8*b +: 8];
        end
    end

    // miss -> block read, store hit -> write-through
    assign mem_req.valid      = active && !refill_wait && (!any_hit || is_store);
    assign mem_req.req_type   = any_hit ? req_q.req_type : READ;
    assign mem_req.block_addr = req_q.addr.mem_view.block_addr;
    assign mem_req.data       = merged_blk;

    assign store_wr  = mem_req.valid && mem_ready && any_hit && is_store;
    assign refill_wr = mem_resp.valid;

    // a store only answers once its write-through is taken
    assign core_resp.valid   = active && any_hit && (!is_store || store_wr);
    assign core_resp.rd_data = (any_hit && !is_store) ?
                               word_t'(hit_blk >> (8 * req_q.addr.cache_view.offset)) : '0;

    // writes use the held index, reads follow the live request
    assign arr_en   = core_req.valid || refill_wr || store_wr;
    assign arr_addr = (refill_wr || store_wr) ? req_q.addr.cache_view.index
                                              : core_req.addr.cache_view.index;
    assign data_din = refill_wr ? {2{mem_resp.data}} : {2{store_blk}};

    sram_1rw #(
        .DEPTH     (`N_SETS),
        .WIDTH     (2 * $bits(tag_entry_t)),
        .MASK_BITS (2)
    ) tag_array_i (
        .clk    (clk),
        .rst_aL (rst_aL),
        .en     (arr_en),
        .we     (refill_wr),
        .wmask  (victim),
        .addr   (arr_addr),
        .din    ({2{1'b1, req_q.addr.cache_view.tag}}),
        .dout   (tag_dout)
    );

    generate
        if (CACHE_TYPE == ICACHE) begin : g_way_mask
            sram_1rw #(
                .DEPTH     (`N_SETS),
                .WIDTH     (2 * $bits(block_t)),
                .MASK_BITS (2)
            ) data_array_i (
                .clk    (clk),
                .rst_aL (rst_aL),
                .en     (arr_en),
                .we     (refill_wr || store_wr),
                .wmask  (victim),
                .addr   (arr_addr),
                .din    (data_din),
                .dout   (data_dout)
            );
        end else begin : g_byte_mask
            logic [2*`BLOCK_BYTES-1:0] data_wmask;

            // whole victim way on refill, addressed bytes of the hit way on a store
            assign data_wmask = refill_wr ?
                {{(`BLOCK_BYTES){victim[1]}}, {(`BLOCK_BYTES){victim[0]}}} :
                {{(`BLOCK_BYTES){way_hit[1]}} & byte_mask, {(`BLOCK_BYTES){way_hit[0]}} & byte_mask};

            sram_1rw #(
                .DEPTH     (`N_SETS),
                .WIDTH     (2 * $bits(block_t)),
                .MASK_BITS (2 * `BLOCK_BYTES)
            ) data_array_i (
                .clk    (clk),
                .rst_aL (rst_aL),
                .en     (arr_en),
                .we     (refill_wr || store_wr),
                .wmask  (data_wmask),
                .addr   (arr_addr),
                .din    (data_din),
                .dout   (data_dout)
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q <= core_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            resp_was_valid <= 1'b0;
            refill_wait    <= 1'b0;
            relook         <= 1'b0;
        end else begin
            resp_was_valid <= core_resp.valid;  // masks the still-held request for a cycle
            relook         <= refill_wr;
            if (mem_req.valid && mem_ready && mem_req.req_type == READ) begin
                refill_wait <= 1'b1;
            end else if (relook) begin
                refill_wait <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_aL) req_q.valid |-> !(&way_hit))
        else $error("[ERROR] %0t: block held in both ways", $time);

    assert property (@(posedge clk) disable iff (!rst_aL)
        (core_req.valid && CACHE_TYPE == ICACHE) |-> core_req.req_type == READ)
        else $error("[ERROR] %0t: store sent to the instruction cache", $time);

    assert property (@(posedge clk) disable iff (!rst_aL) core_resp.valid |-> !refill_wait)
        else $error("[ERROR] %0t: response during an outstanding refill", $time);

endmodule

/* rtl/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

    localparam int OFFSET_BITS = $clog2(`BLOCK_BYTES);
    localparam int INDEX_BITS  = $clog2(`N_SETS);
    localparam int TAG_BITS    = `ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    typedef enum logic {READ, WRITE} req_type_t;
    typedef enum logic [1:0] {BYTE, HALFWORD, WORD} req_width_t;
    typedef enum logic {ICACHE, DCACHE} cache_type_t;

    typedef logic [31:0]                         word_t;
    typedef logic [8*`BLOCK_BYTES-1:0]           block_t;
    typedef logic [`ADDR_WIDTH-OFFSET_BITS-1:0]  block_addr_t;

    // address as seen by a cache lookup
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } cache_addr_t;

    // same address as seen by main memory
    typedef struct packed {
        block_addr_t            block_addr;
        logic [OFFSET_BITS-1:0] offset;
    } mem_addr_t;

    typedef union packed {
        cache_addr_t cache_view;
        mem_addr_t   mem_view;
    } addr_u;

    typedef struct packed {
        logic       valid;
        req_type_t  req_type;
        req_width_t width;
        addr_u      addr;
        word_t      wr_data;    // stores only
    } core_req_t;

    typedef struct packed {
        logic  valid;
        word_t rd_data;
    } core_resp_t;

    typedef struct packed {
        logic        valid;
        req_type_t   req_type;
        block_addr_t block_addr;
        block_t      data;      // write-through block
    } mem_req_t;

    typedef struct packed {
        logic   valid;
        block_t data;
    } mem_resp_t;

endpackage

/* rtl/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address width, shared by both caches and main memory
`define ADDR_WIDTH 12

// bytes per cache block, 8 gives a 64-bit block
`define BLOCK_BYTES 8

// sets in each cache
`define N_SETS 16

// cycles from a read grant to its response in mem_ctrl
`define MEM_LATENCY 3

`endif

/* rtl/lfsr_8bit.sv */
module lfsr_8bit (
    input  logic clk,
    input  logic rst_aL,
    output logic out_bit
);

    logic [7:0] state;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1, period 255
    assign feedback = state[7] ^ state[5] ^ state[4] ^ state[3];

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            state <= 8'hb4;     // any nonzero seed works
        end else begin
            state <= {state[6:0], feedback};
        end
    end

    assign out_bit = state[0];  // victim way when the set is full

endmodule

/* rtl/mem_ctrl.sv */
`include "cache_settings.svh"

module mem_ctrl
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_aL,
    input  mem_req_t  imem_req,
    output logic      imem_ready,
    output mem_resp_t imem_resp,
    input  mem_req_t  dmem_req,
    output logic      dmem_ready,
    output mem_resp_t dmem_resp
);

    localparam int N_BLOCKS = 2 ** (`ADDR_WIDTH - OFFSET_BITS);
    localparam int CNT_W    = $clog2(`MEM_LATENCY + 1);

    block_t           mem [N_BLOCKS] = '{default: '0};
    logic             busy;
    logic             rd_pend;      // the job in flight is a read
    logic             owner_d;      // data side owns the job
    logic [CNT_W-1:0] cnt;
    block_addr_t      addr_q;
    logic             resp_valid;
    block_t           resp_data;
    logic             gnt_i;
    logic             gnt_d;
    mem_req_t         gnt_req;

    // instruction side always wins when both ask
    assign imem_ready = !busy;
    assign dmem_ready = !busy && !imem_req.valid;
    assign gnt_i      = imem_req.valid && imem_ready;
    assign gnt_d      = dmem_req.valid && dmem_ready;
    assign gnt_req    = gnt_i ? imem_req : dmem_req;

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            busy       <= 1'b0;
            rd_pend    <= 1'b0;
            owner_d    <= 1'b0;
            cnt        <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (gnt_i || gnt_d) begin
                busy    <= 1'b1;
                owner_d <= gnt_d;
                rd_pend <= (gnt_req.req_type == READ);
                // writes are done at the grant, one cycle to free up
                cnt     <= (gnt_req.req_type == READ) ? CNT_W'(`MEM_LATENCY - 1) : '0;
            end else if (busy) begin
                if (cnt != '0) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    busy       <= 1'b0;
                    resp_valid <= rd_pend;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_i || gnt_d) begin
            addr_q <= gnt_req.block_addr;
            if (gnt_req.req_type == WRITE) begin
                mem[gnt_req.block_addr] <= gnt_req.data;
            end
        end
        if (busy && rd_pend && cnt == '0) begin
            resp_data <= mem[addr_q];
        end
    end

    // read data only goes back to the side that was granted
    assign imem_resp.valid = resp_valid && !owner_d;
    assign imem_resp.data  = resp_data;
    assign dmem_resp.valid = resp_valid && owner_d;
    assign dmem_resp.data  = resp_data;

    assert property (@(posedge clk) disable iff (!rst_aL)
        (gnt_i || gnt_d) |-> !$past(gnt_i || gnt_d))
        else $error("[ERROR] %0t: grant while a job was in flight", $time);

    assert property (@(posedge clk) disable iff (!rst_aL)
        resp_valid |-> $past((gnt_i || gnt_d) && gnt_req.req_type == READ, `MEM_LATENCY + 1))
        else $error("[ERROR] %0t: memory response with no read in flight", $time);

endmodule

/* rtl/mem_top.sv */
`include "cache_settings.svh"

module mem_top
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_aL,
    input  core_req_t  icore_req,
    output core_resp_t icore_resp,
    input  core_req_t  dcore_req,
    output core_resp_t dcore_resp
);

    mem_req_t  imem_req;
    mem_req_t  dmem_req;
    logic      imem_ready;
    logic      dmem_ready;
    mem_resp_t imem_resp;
    mem_resp_t dmem_resp;

    cache #(
        .CACHE_TYPE (ICACHE)
    ) icache_i (
        .clk       (clk),
        .rst_aL    (rst_aL),
        .core_req  (icore_req),
        .core_resp (icore_resp),
        .mem_req   (imem_req),
        .mem_ready (imem_ready),
        .mem_resp  (imem_resp)
    );

    cache #(
        .CACHE_TYPE (DCACHE)
    ) dcache_i (
        .clk       (clk),
        .rst_aL    (rst_aL),
        .core_req  (dcore_req),
        .core_resp (dcore_resp),
        .mem_req   (dmem_req),
        .mem_ready (dmem_ready),
        .mem_resp  (dmem_resp)
    );

    mem_ctrl mem_ctrl_i (
        .clk        (clk),
        .rst_aL     (rst_aL),
        .imem_req   (imem_req),
        .imem_ready (imem_ready),
        .imem_resp  (imem_resp),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready),
        .dmem_resp  (dmem_resp)
    );

endmodule

/* rtl/sram_1rw.sv */
module sram_1rw #(
    parameter int DEPTH     = 16,
    parameter int WIDTH     = 64,
    parameter int MASK_BITS = 8
) (
    input  logic                     clk,
    input  logic                     rst_aL,
    input  logic                     en,
    input  logic                     we,
    input  logic [MASK_BITS-1:0]     wmask,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    localparam int SLICE = WIDTH / MASK_BITS;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            // top bit of each slice is the valid flag in the tag array
            for (int d = 0; d < DEPTH; d++) begin
                for (int s = 0; s < MASK_BITS; s++) begin
                    mem[d][s*SLICE+SLICE-1] <= 1'b0;
                end
            end
        end else if (en) begin
            if (we) begin
                for (int s = 0; s < MASK_BITS; s++) begin
                    if (wmask[s]) begin
                        mem[addr][s*SLICE +: SLICE] <= din[s*SLICE +: SLICE];
                    end
                end
            end else begin
                dout <= mem[addr];      // one-cycle read, holds otherwise
            end
        end
    end

endmodule

/* testbench/mem_top_tb.sv */
`include "cache_settings.svh"

module mem_top_tb
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_BYTES  = 2 ** `ADDR_WIDTH;
    localparam int MAX_CYCLES = 20000;   // ~600 accesses at up to ~15 cycles per miss, plus margin

    logic                   clk = 1'b0;
    logic                   rst_aL;
    logic                   rst_d = 1'b0;       // rst_aL one cycle late
    core_req_t              icore_req;
    core_resp_t             icore_resp;
    core_req_t              dcore_req;
    core_resp_t             dcore_resp;
    logic [7:0]             shadow [MEM_BYTES];
    word_t                  i_expect;
    word_t                  d_expect;
    logic [31:0]            lcg_state;
    int                     cycles = 0;
    logic [`ADDR_WIDTH-1:0] stored_q [$];       // word addresses written through the data cache

    mem_top mem_top_i (
        .clk        (clk),
        .rst_aL     (rst_aL),
        .icore_req  (icore_req),
        .icore_resp (icore_resp),
        .dcore_req  (dcore_req),
        .dcore_resp (dcore_resp)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;      // low bits of the state repeat quickly
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] rand_addr(input req_width_t w);
        logic [`ADDR_WIDTH-1:0] a;
        a = `ADDR_WIDTH'(lcg_next());
        case (w)
            WORD:     a[1:0] = 2'b00;
            HALFWORD: a[0] = 1'b0;
            default:  a = a;
        endcase
        return a;
    endfunction

    // little-endian word of the reference memory
    function automatic word_t shadow_word(input logic [`ADDR_WIDTH-1:0] a);
        int base;
        base = {a[`ADDR_WIDTH-1:2], 2'b00};
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    always_comb begin
        i_expect = shadow_word(icore_req.addr);
        d_expect = shadow_word(dcore_req.addr);
    end

    // a store changes only the bytes of its width, once its response arrives
    always @(negedge clk) begin : shadow_update
        int n;
        n = (dcore_req.width == WORD) ? 4 : (dcore_req.width == HALFWORD) ? 2 : 1;
        if (dcore_resp.valid && dcore_req.req_type == WRITE) begin
            for (int b = 0; b < n; b++) begin
                shadow[dcore_req.addr + b] <= dcore_req.wr_data[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        rst_d  <= rst_aL;
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: accesses still pending after %0d cycles", cycles));
        end
    end

    // quiet during reset and the first cycle out of it
    always @(negedge clk) begin
        if (!rst_aL || !rst_d) begin
            assert (!icore_resp.valid && !dcore_resp.valid)
                else abort_run($sformatf("[ERROR] %0t: response valid around reset", $time));
        end
    end

    assert property (@(posedge clk) disable iff (!rst_aL)
        (dcore_resp.valid && dcore_req.req_type == READ) |-> dcore_resp.rd_data == d_expect)
        else abort_run($sformatf("[ERROR] %0t: load %h returned %h, expected %h",
                                 $time, dcore_req.addr, dcore_resp.rd_data, d_expect));

    assert property (@(posedge clk) disable iff (!rst_aL)
        (dcore_resp.valid && dcore_req.req_type == WRITE) |-> dcore_resp.rd_data == '0)
        else abort_run($sformatf("[ERROR] %0t: store response carried data %h",
                                 $time, dcore_resp.rd_data));

    assert property (@(posedge clk) disable iff (!rst_aL)
        icore_resp.valid |-> icore_resp.rd_data == i_expect)
        else abort_run($sformatf("[ERROR] %0t: fetch %h returned %h, expected %h",
                                 $time, icore_req.addr, icore_resp.rd_data, i_expect));

    // hold one request until its strobe, lat counts the cycles in between
    task automatic run_access(input cache_type_t side, input req_type_t t, input req_width_t w,
                              input logic [`ADDR_WIDTH-1:0] a, input word_t wdata,
                              output int lat);
        core_req_t r;
        r.valid    = 1'b1;
        r.req_type = t;
        r.width    = w;
        r.addr     = addr_u'(a);
        r.wr_data  = wdata;
        if (side == ICACHE) begin
            icore_req = r;
        end else begin
            dcore_req = r;
        end
        lat = 0;
        @(negedge clk);
        while (!(side == ICACHE ? icore_resp.valid : dcore_resp.valid)) begin
            lat++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (side == ICACHE) begin
            icore_req.valid = 1'b0;
        end else begin
            dcore_req.valid = 1'b0;
        end
    endtask

    initial begin
        int                     lat;
        int                     lat_i;
        int                     lat_d;
        logic [31:0]            pick;
        req_width_t             w;
        logic [`ADDR_WIDTH-1:0] a;
        logic [`ADDR_WIDTH-1:0] set_addr [5];

        lcg_state = 32'd71869;
        rst_aL    = 1'b0;
        icore_req = '0;
        dcore_req = '0;
        for (int k = 0; k < MEM_BYTES; k++) begin
            shadow[k] = 8'h00;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_aL = 1'b1;

        // random stores of all widths, each read back as a word
        repeat (160) begin
            w = req_width_t'(2'(lcg_next() % 3));
            a = rand_addr(w);
            run_access(DCACHE, WRITE, w, a, lcg_next(), lat);
            stored_q.push_back({a[`ADDR_WIDTH-1:2], 2'b00});
            run_access(DCACHE, READ, WORD, {a[`ADDR_WIDTH-1:2], 2'b00}, '0, lat);
        end

        // second load of a block must hit
        repeat (20) begin
            a = rand_addr(WORD);
            run_access(DCACHE, READ, WORD, a, '0, lat);
            run_access(DCACHE, READ, WORD, a, '0, lat);
            assert (lat == 1)
                else abort_run($sformatf("[ERROR] %0t: repeated load took %0d cycles", $time, lat));
        end

        // five tags of one set, more than two ways can hold
        pick = lcg_next();
        for (int k = 0; k < 5; k++) begin
            set_addr[k] = {TAG_BITS'(7 * k + 1), INDEX_BITS'(pick), OFFSET_BITS'(0)};
            run_access(DCACHE, WRITE, WORD, set_addr[k], lcg_next(), lat);
            stored_q.push_back(set_addr[k]);
        end
        repeat (15) begin
            run_access(DCACHE, READ, WORD, set_addr[lcg_next() % 5], '0, lat);
        end

        // fetch what the data side wrote through
        for (int k = 0; k < 60; k++) begin
            run_access(ICACHE, READ, WORD, stored_q[stored_q.size() - 1 - k], '0, lat);
        end

        // both sides miss at once and compete for memory
        fork
            repeat (80) begin
                run_access(ICACHE, READ, WORD, rand_addr(WORD), '0, lat_i);
            end
            repeat (80) begin
                run_access(DCACHE, READ, WORD, rand_addr(WORD), '0, lat_d);
            end
        join

        @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/lfsr_8bit.sv
rtl/sram_1rw.sv
rtl/cache.sv
rtl/mem_ctrl.sv
rtl/mem_top.sv
testbench/mem_top_tb.sv
